/* include/sched_defines.svh */
`ifndef SCHED_DEFINES_SVH
`define SCHED_DEFINES_SVH

// Window length in clock cycles.
`define SCHED_WINDOW_CYCLES 100

`define SCHED_COUNT_W 16

// ROB-full flag needs strictly more full cycles than this.
`define SCHED_ROB_THRESHOLD 66

`define SCHED_QUEUE_DEPTH 4

// Receiver credits available after reset.
`define SCHED_CREDITS 2

`endif

/* hdl/sched_event_pkg.sv */
`include "sched_defines.svh"

package sched_event_pkg;

    // Number of comparison classes with one flag each.
    localparam int EV_CLASS_COUNT = 5;

    // Saturating event count over one window.
    typedef logic [`SCHED_COUNT_W-1:0] ev_count_t;

    // Flag positions in the decision vector.
    typedef enum logic [2:0] {
        EV_MULT  = 3'd0,
        EV_MEM   = 3'd1,
        EV_FLUSH = 3'd2,
        EV_ROB   = 3'd3,
        EV_ALU   = 3'd4
    } ev_class_e;

endpackage

/* hdl/sched_decision_pkg.sv */
package sched_decision_pkg;

    // One bit per event class indexed by ev_class_e.
    typedef logic [sched_event_pkg::EV_CLASS_COUNT-1:0] sched_flags_t;

    // Window number that wraps after 255.
    typedef logic [7:0] window_idx_t;

endpackage

/* hdl/event_window_counters.sv */
`include "sched_defines.svh"

module event_window_counters (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       ooo_mult_ev,
    input  logic                       ooo_mem_ev,
    input  logic                       ooo_flush_ev,
    input  logic                       ooo_alu_ev,
    input  logic                       ooo_rob_full_ev,
    input  logic                       ppl_mult_ev,
    input  logic                       ppl_mem_ev,
    input  logic                       ppl_flush_ev,
    input  logic                       ppl_alu_ev,
    output logic                       snap_valid,
    output sched_event_pkg::ev_count_t snap_ooo_mult,
    output sched_event_pkg::ev_count_t snap_ppl_mult,
    output sched_event_pkg::ev_count_t snap_ooo_mem,
    output sched_event_pkg::ev_count_t snap_ppl_mem,
    output sched_event_pkg::ev_count_t snap_ooo_flush,
    output sched_event_pkg::ev_count_t snap_ppl_flush,
    output sched_event_pkg::ev_count_t snap_rob_full,
    output sched_event_pkg::ev_count_t snap_ooo_alu,
    output sched_event_pkg::ev_count_t snap_ppl_alu
);
    import sched_event_pkg::*;

    localparam int NUM_EV = 9;
    localparam int TIMER_W = $clog2(`SCHED_WINDOW_CYCLES);
    localparam logic [TIMER_W-1:0] TIMER_LAST = TIMER_W'(`SCHED_WINDOW_CYCLES - 1);

    logic [TIMER_W-1:0] timer;
    logic               terminal;
    logic [NUM_EV-1:0]  ev;
    ev_count_t          cnt  [NUM_EV];
    ev_count_t          snap [NUM_EV];

    assign terminal = (timer == TIMER_LAST);

    // Counter slots pair the ooo and ppl events of each class.
    assign ev[0] = ooo_mult_ev;
    assign ev[1] = ppl_mult_ev;
    assign ev[2] = ooo_mem_ev;
    assign ev[3] = ppl_mem_ev;
    assign ev[4] = ooo_flush_ev;
    assign ev[5] = ppl_flush_ev;
    assign ev[6] = ooo_rob_full_ev;
    assign ev[7] = ooo_alu_ev;
    assign ev[8] = ppl_alu_ev;

    always_ff @(posedge clk) begin
        if (rst) begin
            timer <= '0;
        end else if (terminal) begin
            timer <= '0;
        end else begin
            timer <= timer + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || terminal) begin
            for (int i = 0; i < NUM_EV; i++) begin
                cnt[i] <= '0; // Terminal-cycle events are dropped here.
            end
        end else begin
            for (int i = 0; i < NUM_EV; i++) begin
                if (ev[i] && (cnt[i] != '1)) begin
                    cnt[i] <= cnt[i] + 1'b1; // Saturates at all ones.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (terminal) begin
            for (int i = 0; i < NUM_EV; i++) begin
                snap[i] <= cnt[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            snap_valid <= 1'b0;
        end else begin
            snap_valid <= terminal; // One-cycle pulse after window end.
        end
    end

    assign snap_ooo_mult  = snap[0];
    assign snap_ppl_mult  = snap[1];
    assign snap_ooo_mem   = snap[2];
    assign snap_ppl_mem   = snap[3];
    assign snap_ooo_flush = snap[4];
    assign snap_ppl_flush = snap[5];
    assign snap_rob_full  = snap[6];
    assign snap_ooo_alu   = snap[7];
    assign snap_ppl_alu   = snap[8];

endmodule

/* hdl/rate_comparator.sv */
`include "sched_defines.svh"

module rate_comparator (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          snap_valid,
    input  sched_event_pkg::ev_count_t    snap_ooo_mult,
    input  sched_event_pkg::ev_count_t    snap_ppl_mult,
    input  sched_event_pkg::ev_count_t    snap_ooo_mem,
    input  sched_event_pkg::ev_count_t    snap_ppl_mem,
    input  sched_event_pkg::ev_count_t    snap_ooo_flush,
    input  sched_event_pkg::ev_count_t    snap_ppl_flush,
    input  sched_event_pkg::ev_count_t    snap_rob_full,
    input  sched_event_pkg::ev_count_t    snap_ooo_alu,
    input  sched_event_pkg::ev_count_t    snap_ppl_alu,
    output logic                          flags_valid,
    output sched_decision_pkg::sched_flags_t flags
);
    import sched_event_pkg::*;

    localparam ev_count_t ROB_LIMIT = ev_count_t'(`SCHED_ROB_THRESHOLD);

    // Flags hold until the next snapshot.
    always_ff @(posedge clk) begin
        if (snap_valid) begin
            flags[EV_MULT]  <= (snap_ooo_mult < snap_ppl_mult); // Ppl multiplies more.
            flags[EV_MEM]   <= (snap_ooo_mem > snap_ppl_mem);
            flags[EV_FLUSH] <= (snap_ooo_flush > snap_ppl_flush);
            flags[EV_ROB]   <= (snap_rob_full > ROB_LIMIT); // ROB often saturated.
            flags[EV_ALU]   <= (snap_ooo_alu < snap_ppl_alu);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flags_valid <= 1'b0;
        end else begin
            flags_valid <= snap_valid;
        end
    end

endmodule

/* hdl/mode_vote.sv */
module mode_vote (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             flags_valid,
    input  sched_decision_pkg::sched_flags_t flags,
    output logic                             rec_valid,
    output sched_decision_pkg::window_idx_t  rec_window,
    output sched_decision_pkg::sched_flags_t rec_flags,
    output logic                             rec_switch
);
    import sched_event_pkg::*;
    import sched_decision_pkg::*;

    window_idx_t next_window;
    logic [2:0]  flag_sum;
    logic        vote;

    assign flag_sum = 3'($countones(flags));

    // Majority of flags, or a saturated ROB with ALU-bound ppl.
    assign vote = (flag_sum >= 3'd3) || (flags[EV_ROB] && flags[EV_ALU]);

    always_ff @(posedge clk) begin
        if (rst) begin
            rec_valid   <= 1'b0;
            next_window <= '0;
        end else begin
            rec_valid <= flags_valid;
            if (flags_valid) begin
                next_window <= next_window + 1'b1; // Wraps at 255.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (flags_valid) begin
            rec_window <= next_window;
            rec_flags  <= flags;
            rec_switch <= vote;
        end
    end

endmodule

/* hdl/decision_credit_tx.sv */
`include "sched_defines.svh"

module decision_credit_tx (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             rec_valid,
    input  sched_decision_pkg::window_idx_t  rec_window,
    input  sched_decision_pkg::sched_flags_t rec_flags,
    input  logic                             rec_switch,
    input  logic                             credit_return,
    output logic                             dec_valid,
    output sched_decision_pkg::window_idx_t  dec_window,
    output sched_decision_pkg::sched_flags_t dec_flags,
    output logic                             dec_switch,
    output logic [7:0]                       drop_count
);
    import sched_decision_pkg::*;

    localparam int DEPTH  = `SCHED_QUEUE_DEPTH;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int CRED_W = $clog2(`SCHED_CREDITS + DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

    window_idx_t        q_window [DEPTH];
    sched_flags_t       q_flags  [DEPTH];
    logic               q_switch [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic [CRED_W-1:0]  credits;
    logic               full;
    logic               push;
    logic               pop;

    assign full = (count == CNT_W'(DEPTH));
    assign push = rec_valid && !full; // A record meeting a full queue is lost.
    assign pop  = (count != '0) && (credits != '0);

    assign dec_valid  = pop;
    assign dec_window = q_window[rd_ptr];
    assign dec_flags  = q_flags[rd_ptr];
    assign dec_switch = q_switch[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            q_window[wr_ptr] <= rec_window;
            q_flags[wr_ptr]  <= rec_flags;
            q_switch[wr_ptr] <= rec_switch;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credits    <= CRED_W'(`SCHED_CREDITS);
            drop_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            count   <= count + CNT_W'(push) - CNT_W'(pop);
            credits <= credits + CRED_W'(credit_return) - CRED_W'(pop); // Send costs one.
            if (rec_valid && full && (drop_count != 8'hff)) begin
                drop_count <= drop_count + 1'b1; // Saturates at 255.
            end
        end
    end

endmodule

/* hdl/sched_top.sv */
module sched_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             ooo_mult_ev,
    input  logic                             ooo_mem_ev,
    input  logic                             ooo_flush_ev,
    input  logic                             ooo_alu_ev,
    input  logic                             ooo_rob_full_ev,
    input  logic                             ppl_mult_ev,
    input  logic                             ppl_mem_ev,
    input  logic                             ppl_flush_ev,
    input  logic                             ppl_alu_ev,
    input  logic                             credit_return,
    output logic                             dec_valid,
    output sched_decision_pkg::window_idx_t  dec_window,
    output sched_decision_pkg::sched_flags_t dec_flags,
    output logic                             dec_switch,
    output logic [7:0]                       drop_count
);
    import sched_event_pkg::*;
    import sched_decision_pkg::*;

    logic         snap_valid;
    ev_count_t    snap_ooo_mult;
    ev_count_t    snap_ppl_mult;
    ev_count_t    snap_ooo_mem;
    ev_count_t    snap_ppl_mem;
    ev_count_t    snap_ooo_flush;
    ev_count_t    snap_ppl_flush;
    ev_count_t    snap_rob_full;
    ev_count_t    snap_ooo_alu;
    ev_count_t    snap_ppl_alu;
    logic         flags_valid;
    sched_flags_t flags;
    logic         rec_valid;
    window_idx_t  rec_window;
    sched_flags_t rec_flags;
    logic         rec_switch;

    event_window_counters event_window_counters_i (
        .clk(clk), .rst(rst),
        .ooo_mult_ev(ooo_mult_ev), .ooo_mem_ev(ooo_mem_ev),
        .ooo_flush_ev(ooo_flush_ev), .ooo_alu_ev(ooo_alu_ev),
        .ooo_rob_full_ev(ooo_rob_full_ev),
        .ppl_mult_ev(ppl_mult_ev), .ppl_mem_ev(ppl_mem_ev),
        .ppl_flush_ev(ppl_flush_ev), .ppl_alu_ev(ppl_alu_ev),
        .snap_valid(snap_valid),
        .snap_ooo_mult(snap_ooo_mult), .snap_ppl_mult(snap_ppl_mult),
        .snap_ooo_mem(snap_ooo_mem), .snap_ppl_mem(snap_ppl_mem),
        .snap_ooo_flush(snap_ooo_flush), .snap_ppl_flush(snap_ppl_flush),
        .snap_rob_full(snap_rob_full),
        .snap_ooo_alu(snap_ooo_alu), .snap_ppl_alu(snap_ppl_alu)
    );

    rate_comparator rate_comparator_i (
        .clk(clk), .rst(rst), .snap_valid(snap_valid),
        .snap_ooo_mult(snap_ooo_mult), .snap_ppl_mult(snap_ppl_mult),
        .snap_ooo_mem(snap_ooo_mem), .snap_ppl_mem(snap_ppl_mem),
        .snap_ooo_flush(snap_ooo_flush), .snap_ppl_flush(snap_ppl_flush),
        .snap_rob_full(snap_rob_full),
        .snap_ooo_alu(snap_ooo_alu), .snap_ppl_alu(snap_ppl_alu),
        .flags_valid(flags_valid), .flags(flags)
    );

    mode_vote mode_vote_i (
        .clk(clk), .rst(rst),
        .flags_valid(flags_valid), .flags(flags),
        .rec_valid(rec_valid), .rec_window(rec_window),
        .rec_flags(rec_flags), .rec_switch(rec_switch)
    );

    decision_credit_tx decision_credit_tx_i (
        .clk(clk), .rst(rst),
        .rec_valid(rec_valid), .rec_window(rec_window),
        .rec_flags(rec_flags), .rec_switch(rec_switch),
        .credit_return(credit_return),
        .dec_valid(dec_valid), .dec_window(dec_window),
        .dec_flags(dec_flags), .dec_switch(dec_switch),
        .drop_count(drop_count)
    );

endmodule

/* verif/sched_tb.sv */
`include "sched_defines.svh"

module sched_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import sched_event_pkg::*;
    import sched_decision_pkg::*;

    localparam int W           = `SCHED_WINDOW_CYCLES;
    localparam int CREDITS     = `SCHED_CREDITS;
    localparam int DEPTH       = `SCHED_QUEUE_DEPTH;
    localparam int ROWS        = 26;
    localparam int ROB_COL     = 6;
    localparam int HOLD_COL    = 9;
    localparam int TERM_COL    = 10;
    localparam int WATCHDOG_NS = (ROWS + 4) * W * 10 + 500;

    // Column order is ooo_mult ppl_mult ooo_mem ppl_mem ooo_flush ppl_flush
    // rob_len ooo_alu ppl_alu hold term. Event columns hold a period, except
    // rob_len, the number of leading cycles with the ROB full.
    localparam int STIM_TAB [ROWS][11] = '{
        '{0, 0, 0, 0, 0, 0,  0, 0, 0, 0, 0},
        '{4, 2, 0, 0, 0, 0,  0, 0, 0, 0, 0},
        '{2, 2, 3, 3, 5, 5, 66, 1, 1, 0, 0}, // Equal counts, ROB at threshold.
        '{0, 0, 2, 4, 3, 0, 66, 0, 0, 0, 0},
        '{0, 0, 0, 0, 0, 0, 67, 4, 1, 0, 0}, // ROB just above threshold.
        '{0, 3, 1, 2, 2, 0,  0, 0, 0, 0, 0},
        '{0, 2, 0, 0, 0, 0,  0, 0, 1, 0, 0},
        '{0, 0, 2, 0, 0, 0, 80, 0, 0, 0, 0},
        '{0, 0, 0, 0, 1, 3, 70, 0, 0, 0, 0},
        '{5, 1, 0, 0, 0, 0, 67, 0, 0, 0, 0},
        '{0, 0, 1, 7, 0, 0,  0, 7, 1, 0, 0},
        '{3, 1, 1, 2, 1, 2, 99, 3, 1, 0, 1},
        '{0, 0, 0, 0, 0, 0,  0, 0, 0, 0, 0},
        '{0, 1, 1, 0, 1, 0, 90, 0, 0, 0, 0},
        '{0, 1, 0, 0, 1, 0,  0, 0, 0, 0, 0},
        '{0, 0, 0, 0, 1, 0,  0, 0, 1, 0, 0},
        '{0, 1, 1, 0, 0, 0,  0, 0, 0, 0, 0},
        '{0, 0, 1, 0, 1, 0,  0, 0, 1, 1, 0}, // Credits held from here.
        '{0, 2, 0, 0, 0, 0,  0, 0, 0, 1, 0},
        '{0, 0, 0, 0, 0, 0, 67, 0, 1, 1, 0},
        '{0, 0, 0, 0, 0, 0,  0, 0, 0, 1, 0},
        '{1, 1, 0, 0, 0, 0,  0, 0, 0, 1, 0},
        '{0, 0, 2, 0, 0, 0,  0, 0, 0, 1, 0},
        '{0, 1, 1, 0, 1, 0,  0, 0, 0, 1, 0},
        '{0, 0, 0, 0, 0, 0,  0, 3, 2, 0, 0},
        '{0, 0, 0, 0, 0, 0, 66, 0, 0, 0, 1}  // Terminal pulses would lift ROB past threshold.
    };

    typedef struct packed {
        window_idx_t  win;
        sched_flags_t flags;
        logic         sw;
    } rec_t;

    logic         clk;
    logic         rst;
    logic         ooo_mult_ev;
    logic         ooo_mem_ev;
    logic         ooo_flush_ev;
    logic         ooo_alu_ev;
    logic         ooo_rob_full_ev;
    logic         ppl_mult_ev;
    logic         ppl_mem_ev;
    logic         ppl_flush_ev;
    logic         ppl_alu_ev;
    logic         credit_return;
    logic         dec_valid;
    window_idx_t  dec_window;
    sched_flags_t dec_flags;
    logic         dec_switch;
    logic [7:0]   drop_count;

    logic hold;
    int   cnt_tab [ROWS][9];
    rec_t exp_q [$];
    int   model_credits;
    int   model_drops;
    int   cyc;
    int   sent_cnt;
    int   returned_cnt;
    int   check_errors;
    int   final_errors;

    sched_top sched_top_i (
        .clk(clk), .rst(rst),
        .ooo_mult_ev(ooo_mult_ev), .ooo_mem_ev(ooo_mem_ev),
        .ooo_flush_ev(ooo_flush_ev), .ooo_alu_ev(ooo_alu_ev),
        .ooo_rob_full_ev(ooo_rob_full_ev),
        .ppl_mult_ev(ppl_mult_ev), .ppl_mem_ev(ppl_mem_ev),
        .ppl_flush_ev(ppl_flush_ev), .ppl_alu_ev(ppl_alu_ev),
        .credit_return(credit_return),
        .dec_valid(dec_valid), .dec_window(dec_window),
        .dec_flags(dec_flags), .dec_switch(dec_switch),
        .drop_count(drop_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic set_events(input logic [8:0] ev);
        ooo_mult_ev     <= ev[0];
        ppl_mult_ev     <= ev[1];
        ooo_mem_ev      <= ev[2];
        ppl_mem_ev      <= ev[3];
        ooo_flush_ev    <= ev[4];
        ppl_flush_ev    <= ev[5];
        ooo_rob_full_ev <= ev[6];
        ooo_alu_ev      <= ev[7];
        ppl_alu_ev      <= ev[8];
    endtask

    task automatic drive_row_cycle(input int r, input int c);
        logic [8:0] ev;
        int         p;
        ev = '0;
        if (c < W - 1) begin
            for (int i = 0; i < 9; i++) begin
                p = STIM_TAB[r][i];
                if (i == ROB_COL) begin
                    ev[i] = (c < p);
                end else if (p != 0) begin
                    ev[i] = ((c % p) == 0);
                end
                if (ev[i]) begin
                    cnt_tab[r][i]++;
                end
            end
        end else if (STIM_TAB[r][TERM_COL] != 0) begin
            ev = '1; // Terminal-cycle pulses stay out of the counts.
        end
        set_events(ev);
    endtask

    function automatic rec_t expect_record(input int k);
        sched_flags_t f;
        int           n;
        rec_t         rec;
        f = '0;
        f[EV_MULT]  = (cnt_tab[k][0] < cnt_tab[k][1]);
        f[EV_MEM]   = (cnt_tab[k][2] > cnt_tab[k][3]);
        f[EV_FLUSH] = (cnt_tab[k][4] > cnt_tab[k][5]);
        f[EV_ROB]   = (cnt_tab[k][6] > `SCHED_ROB_THRESHOLD);
        f[EV_ALU]   = (cnt_tab[k][7] < cnt_tab[k][8]);
        n = 0;
        for (int i = 0; i < 5; i++) begin
            n += int'(f[i]);
        end
        rec.win   = window_idx_t'(k);
        rec.flags = f;
        rec.sw    = (n >= 3) || (f[EV_ROB] && f[EV_ALU]);
        return rec;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            check_errors++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h at cycle %0d",
                     name, got, expected, cyc);
        end
    endtask

    // Output side model steps once per cycle at the falling edge.
    initial begin : monitor
        int   k;
        logic exp_valid;
        logic full;
        rec_t head;
        cyc           = 0;
        model_credits = CREDITS;
        model_drops   = 0;
        sent_cnt      = 0;
        check_errors  = 0;
        forever begin
            @(negedge clk);
            if (rst) begin
                check_value("dec_valid", 32'(dec_valid), 32'd0);
                check_value("drop_count", 32'(drop_count), 32'd0);
                exp_q.delete();
                model_credits = CREDITS;
                model_drops   = 0;
                cyc           = 0;
            end else begin
                check_value("drop_count", 32'(drop_count), 32'(model_drops));
                exp_valid = (exp_q.size() > 0) && (model_credits > 0);
                check_value("dec_valid", 32'(dec_valid), 32'(exp_valid));
                full = (exp_q.size() == DEPTH);
                if (exp_valid) begin
                    head = exp_q.pop_front();
                    check_value("dec_window", 32'(dec_window), 32'(head.win));
                    check_value("dec_flags", 32'(dec_flags), 32'(head.flags));
                    check_value("dec_switch", 32'(dec_switch), 32'(head.sw));
                end
                if (dec_valid) begin
                    sent_cnt++;
                end
                // Window k's record reaches the queue two cycles into window k+1.
                if ((cyc >= W + 2) && (((cyc - 2) % W) == 0)) begin
                    k = (cyc - 2) / W - 1;
                    if (k < ROWS) begin
                        if (full) begin
                            if (model_drops < 255) begin
                                model_drops++;
                            end
                        end else begin
                            exp_q.push_back(expect_record(k));
                        end
                    end
                end
                model_credits = model_credits + int'(credit_return) - int'(exp_valid);
                cyc++;
            end
        end
    end

    // Each dec_valid earns one credit back in a later cycle.
    initial begin : credit_returner
        credit_return = 1'b0;
        returned_cnt  = 0;
        forever begin
            @(posedge clk);
            if (!rst && !hold && (sent_cnt > returned_cnt)) begin
                credit_return <= 1'b1;
                returned_cnt++;
            end else begin
                credit_return <= 1'b0;
            end
        end
    end

    initial begin : stimulus
        int held;
        int exp_drops;
        int waited;
        rst          = 1'b1;
        hold         = 1'b0;
        final_errors = 0;
        set_events('0);
        for (int r = 0; r < ROWS; r++) begin
            for (int i = 0; i < 9; i++) begin
                cnt_tab[r][i] = 0;
            end
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int r = 0; r < ROWS; r++) begin
            hold <= (STIM_TAB[r][HOLD_COL] != 0);
            for (int c = 0; c < W; c++) begin
                drive_row_cycle(r, c);
                @(posedge clk);
            end
        end
        hold <= 1'b0;
        set_events('0);
        // The record landing as credits resume also meets a full queue.
        held = 0;
        for (int r = 0; r < ROWS; r++) begin
            held += STIM_TAB[r][HOLD_COL];
        end
        exp_drops = held + 1 - CREDITS - DEPTH;
        waited = 0;
        while ((sent_cnt < ROWS - exp_drops) && (waited < W)) begin
            @(posedge clk);
            waited++;
        end
        @(negedge clk);
        assert (sent_cnt == ROWS - exp_drops) else begin
            final_errors++;
            $display("output did not drain, %0d records sent where %0d were due", sent_cnt,
                     ROWS - exp_drops);
        end
        assert (int'(drop_count) == exp_drops) else begin
            final_errors++;
            $display("mismatch drop_count: got 0x%0h, expected 0x%0h", drop_count, exp_drops);
        end
        $display("errors: %0d in cycle checks, %0d in final checks", check_errors,
                 final_errors);
        if ((check_errors + final_errors) == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("errors: %0d in cycle checks, %0d in final checks", check_errors,
                 final_errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* sim.f */
+incdir+include
hdl/sched_event_pkg.sv
hdl/sched_decision_pkg.sv
hdl/event_window_counters.sv
hdl/rate_comparator.sv
hdl/mode_vote.sv
hdl/decision_credit_tx.sv
hdl/sched_top.sv
verif/sched_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module sched_tb -o sched_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sched_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" <<< "$output"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
